//--- logic/fu_pkg.sv
`default_nettype none

package fu_pkg;

    ////////////////////////////////////////
    // Widths
    ////////////////////////////////////////

    // Datapath word
    localparam int WORD_W = 32;
    // Physical register tag
    localparam int PREG_W = 6;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [PREG_W-1:0] preg_t;

    // Instruction fields
    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;

    // SRAI shift amount, low imm bits
    typedef logic [4:0] shamt_t;

    ////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////

    // Decoded operation
    typedef enum logic [2:0] {
        OP_ADD,
        OP_XOR,
        OP_ADDI,
        OP_ORI,
        OP_SRAI,
        OP_LUI
    } alu_op_t;

    // Dispatch occupancy
    typedef enum logic [1:0] {
        DS_IDLE,
        DS_BUSY,
        DS_FULL
    } disp_state_t;

    // Default unit count
    localparam int NUM_ALU_DEF = 3;

endpackage

`default_nettype wire

//--- logic/alu_issue_if.sv
`timescale 1ns/1ps
`default_nettype none

// Issue side of one ALU
// sel is the one-hot unit select, same vector in every instance
interface alu_issue_if #(
    parameter int NUM_ALU = fu_pkg::NUM_ALU_DEF
);
    logic [NUM_ALU-1:0] sel;
    fu_pkg::alu_op_t    op;
    fu_pkg::word_t      src1;
    fu_pkg::word_t      src2;
    fu_pkg::word_t      imm;
    fu_pkg::preg_t      dr;

    // Dispatch, decoder and top drive
    modport disp (output sel, output op, output src1, output src2, output imm, output dr);
    // ALU reads
    modport fu (input sel, input op, input src1, input src2, input imm, input dr);
endinterface

// Result side of one ALU
// valid holds with data and tag until ack
interface alu_result_if;
    logic          valid;
    fu_pkg::word_t data;
    fu_pkg::preg_t dr;
    logic          ack;

    modport fu (output valid, output data, output dr, input ack);
    modport arb (input valid, input data, input dr, output ack);
endinterface

`default_nettype wire

//--- logic/op_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module op_decoder (
    input  wire fu_pkg::opcode_t opcode,
    input  wire fu_pkg::funct3_t func3,
    input  wire fu_pkg::funct7_t func7,
    output fu_pkg::alu_op_t      op,
    output logic                 legal
);

    // Major opcodes
    localparam fu_pkg::opcode_t OPC_RTYPE = 7'b0110011;
    localparam fu_pkg::opcode_t OPC_ITYPE = 7'b0010011;
    localparam fu_pkg::opcode_t OPC_LUI   = 7'b0110111;

    // Upper field for arithmetic shift
    localparam fu_pkg::funct7_t F7_ALT = 7'b0100000;

    always_comb begin
        // Unsupported by default, loads and stores land here
        op    = fu_pkg::OP_ADD;
        legal = 1'b0;
        case (opcode)
            OPC_RTYPE: begin
                if (func3 == 3'b000 && func7 == 7'b0000000) begin
                    op    = fu_pkg::OP_ADD;
                    legal = 1'b1;
                end else if (func3 == 3'b100) begin
                    op    = fu_pkg::OP_XOR;
                    legal = 1'b1;
                end
            end
            OPC_ITYPE: begin
                if (func3 == 3'b000) begin
                    op    = fu_pkg::OP_ADDI;
                    legal = 1'b1;
                end else if (func3 == 3'b110) begin
                    op    = fu_pkg::OP_ORI;
                    legal = 1'b1;
                end else if (func3 == 3'b101 && func7 == F7_ALT) begin
                    // SRAI only, SRLI not supported
                    op    = fu_pkg::OP_SRAI;
                    legal = 1'b1;
                end
            end
            OPC_LUI: begin
                // No field tests for U-type
                op    = fu_pkg::OP_LUI;
                legal = 1'b1;
            end
            default: begin
                legal = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- logic/shift_timer.sv
`timescale 1ns/1ps
`default_nettype none

module shift_timer (
    input  wire                 clk,
    input  wire                 rstn,
    input  wire                 load,
    input  wire fu_pkg::shamt_t amount,
    output logic                step,
    output logic                done
);

    fu_pkg::shamt_t count;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            count <= '0;
            done  <= 1'b0;
        end else if (load) begin
            count <= amount;
            // Zero amount finishes at once
            done  <= (amount == '0);
        end else if (count != '0) begin
            count <= count - 1'b1;
            // Last step
            done  <= (count == fu_pkg::shamt_t'(1));
        end else begin
            done  <= 1'b0;
        end
    end

    // One shift per cycle while counting
    assign step = (count != '0);

endmodule

`default_nettype wire

//--- logic/dispatch_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module dispatch_fsm #(
    parameter int NUM_ALU = fu_pkg::NUM_ALU_DEF
) (
    input  wire               clk,
    input  wire               rstn,
    input  wire               issue_valid,
    input  wire               legal,
    input  wire [NUM_ALU-1:0] fu_ready,
    alu_issue_if.disp         issue [NUM_ALU],
    output logic              issue_stall,
    output logic              illegal_op
);

    fu_pkg::disp_state_t state_q;
    fu_pkg::disp_state_t state_d;

    logic               accept;
    logic [NUM_ALU-1:0] pick;
    logic [NUM_ALU-1:0] sel_vec;
    logic [NUM_ALU-1:0] left;

    ////////////////////////////////////////
    // Unit choice
    ////////////////////////////////////////

    // Source holds while stalled
    assign accept = issue_valid && !issue_stall;

    // Lowest-numbered ready unit
    always_comb begin
        pick = '0;
        for (int i = 0; i < NUM_ALU; i++) begin
            if (fu_ready[i] && pick == '0) begin
                pick[i] = 1'b1;
            end
        end
    end

    // Illegal ones are swallowed, no select
    assign sel_vec = (accept && legal) ? pick : '0;

    // Same one-hot vector to every unit, each takes its own bit
    for (genvar g = 0; g < NUM_ALU; g++) begin : g_sel
        assign issue[g].sel = sel_vec;
    end

    ////////////////////////////////////////
    // Occupancy FSM
    ////////////////////////////////////////

    // Units still free after this edge
    assign left = fu_ready & ~sel_vec;

    always_comb begin
        if (left == '0) begin
            // Took the last one, or all held
            state_d = fu_pkg::DS_FULL;
        end else if (&left) begin
            state_d = fu_pkg::DS_IDLE;
        end else begin
            state_d = fu_pkg::DS_BUSY;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state_q    <= fu_pkg::DS_IDLE;
            illegal_op <= 1'b0;
        end else begin
            state_q    <= state_d;
            // One-cycle pulse after accepting edge
            illegal_op <= accept && !legal;
        end
    end

    // Straight from the state register
    assign issue_stall = (state_q == fu_pkg::DS_FULL);

endmodule

`default_nettype wire

//--- logic/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu #(
    parameter int ALU_NO = 0
) (
    input  wire      clk,
    input  wire      rstn,
    alu_issue_if.fu  issue,
    alu_result_if.fu result,
    output logic     fu_ready
);

    localparam int W = fu_pkg::WORD_W;

    logic            take;
    logic            finish;
    logic            pending;
    logic            valid_q;
    logic            sh_load;
    logic            sh_step;
    logic            sh_done;
    fu_pkg::alu_op_t op_q;
    fu_pkg::word_t   a_q;
    fu_pkg::word_t   b_q;
    fu_pkg::word_t   res_d;
    fu_pkg::word_t   res_q;
    fu_pkg::preg_t   dr_q;

    // Own bit of the one-hot select
    assign take    = issue.sel[ALU_NO];
    assign sh_load = take && (issue.op == fu_pkg::OP_SRAI);

    shift_timer u_timer (
        .clk    (clk),
        .rstn   (rstn),
        .load   (sh_load),
        .amount (issue.imm[4:0]),
        .step   (sh_step),
        .done   (sh_done)
    );

    // One-cycle ops finish on the next edge, SRAI waits for the timer
    assign finish = pending && ((op_q != fu_pkg::OP_SRAI) || sh_done);

    ////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////

    always_comb begin
        case (op_q)
            fu_pkg::OP_ADD,
            fu_pkg::OP_ADDI: res_d = a_q + b_q;
            fu_pkg::OP_XOR:  res_d = a_q ^ b_q;
            fu_pkg::OP_ORI:  res_d = a_q | b_q;
            fu_pkg::OP_LUI:  res_d = b_q << 12;
            // SRAI already shifted in place
            default:         res_d = a_q;
        endcase
    end

    always_ff @(posedge clk) begin
        if (take) begin
            op_q <= issue.op;
            dr_q <= issue.dr;
            a_q  <= issue.src1;
            // R-type takes src2, everything else the immediate
            if (issue.op == fu_pkg::OP_ADD || issue.op == fu_pkg::OP_XOR) begin
                b_q <= issue.src2;
            end else begin
                b_q <= issue.imm;
            end
        end else if (sh_step) begin
            // One bit right, sign fill
            a_q <= {a_q[W-1], a_q[W-1:1]};
        end
        if (finish) begin
            res_q <= res_d;
        end
    end

    ////////////////////////////////////////
    // Control
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rstn) begin
            pending  <= 1'b0;
            valid_q  <= 1'b0;
            fu_ready <= 1'b1;
        end else begin
            if (take) begin
                pending  <= 1'b1;
                fu_ready <= 1'b0;
            end else if (finish) begin
                pending <= 1'b0;
                valid_q <= 1'b1;
            end
            // Held until the arbiter takes it
            if (valid_q && result.ack) begin
                valid_q  <= 1'b0;
                fu_ready <= 1'b1;
            end
        end
    end

    assign result.valid = valid_q;
    assign result.data  = res_q;
    assign result.dr    = dr_q;

endmodule

`default_nettype wire

//--- logic/writeback_arb.sv
`timescale 1ns/1ps
`default_nettype none

module writeback_arb #(
    parameter int NUM_ALU = fu_pkg::NUM_ALU_DEF
) (
    input  wire           clk,
    input  wire           rstn,
    alu_result_if.arb     result [NUM_ALU],
    output logic          wb_valid,
    output fu_pkg::word_t wb_data,
    output fu_pkg::preg_t wb_dr
);

    logic [NUM_ALU-1:0] req;
    logic [NUM_ALU-1:0] grant;
    fu_pkg::word_t      data_arr [NUM_ALU];
    fu_pkg::preg_t      dr_arr   [NUM_ALU];
    fu_pkg::word_t      win_data;
    fu_pkg::preg_t      win_dr;

    // Flatten the port array
    for (genvar g = 0; g < NUM_ALU; g++) begin : g_unit
        assign req[g]       = result[g].valid;
        assign data_arr[g]  = result[g].data;
        assign dr_arr[g]    = result[g].dr;
        // Ack in the grant cycle, unit drops valid at the edge
        assign result[g].ack = grant[g];
    end

    ////////////////////////////////////////
    // Fixed priority, unit 0 first
    ////////////////////////////////////////

    always_comb begin
        grant    = '0;
        win_data = '0;
        win_dr   = '0;
        for (int i = 0; i < NUM_ALU; i++) begin
            if (req[i] && grant == '0) begin
                grant[i] = 1'b1;
                win_data = data_arr[i];
                win_dr   = dr_arr[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= |grant;
        end
    end

    // Payload only moves with a grant
    always_ff @(posedge clk) begin
        if (|grant) begin
            wb_data <= win_data;
            wb_dr   <= win_dr;
        end
    end

endmodule

`default_nettype wire

//--- logic/exec_cluster.sv
`timescale 1ns/1ps
`default_nettype none

module exec_cluster #(
    parameter int NUM_ALU = fu_pkg::NUM_ALU_DEF
) (
    input  wire                  clk,
    input  wire                  rstn,
    // Issue stage
    input  wire                  issue_valid,
    input  wire fu_pkg::opcode_t opcode,
    input  wire fu_pkg::funct3_t func3,
    input  wire fu_pkg::funct7_t func7,
    input  wire fu_pkg::word_t   data_in_sr1,
    input  wire fu_pkg::word_t   data_in_sr2,
    input  wire fu_pkg::word_t   data_in_imm,
    input  wire fu_pkg::preg_t   dr_in,
    output logic                 issue_stall,
    // Writeback
    output logic                 wb_valid,
    output fu_pkg::word_t        wb_data,
    output fu_pkg::preg_t        wb_dr,
    output logic                 illegal_op
);

    fu_pkg::alu_op_t    dec_op;
    logic               dec_legal;
    logic [NUM_ALU-1:0] fu_ready;

    alu_issue_if #(.NUM_ALU(NUM_ALU)) issue_if [NUM_ALU] ();
    alu_result_if                     result_if [NUM_ALU] ();

    op_decoder u_dec (
        .opcode (opcode),
        .func3  (func3),
        .func7  (func7),
        .op     (dec_op),
        .legal  (dec_legal)
    );

    dispatch_fsm #(.NUM_ALU(NUM_ALU)) u_disp (
        .clk         (clk),
        .rstn        (rstn),
        .issue_valid (issue_valid),
        .legal       (dec_legal),
        .fu_ready    (fu_ready),
        .issue       (issue_if),
        .issue_stall (issue_stall),
        .illegal_op  (illegal_op)
    );

    ////////////////////////////////////////
    // Functional units
    ////////////////////////////////////////

    for (genvar g = 0; g < NUM_ALU; g++) begin : g_alu
        // Operands fan out, the select picks the taker
        assign issue_if[g].op   = dec_op;
        assign issue_if[g].src1 = data_in_sr1;
        assign issue_if[g].src2 = data_in_sr2;
        assign issue_if[g].imm  = data_in_imm;
        assign issue_if[g].dr   = dr_in;

        alu #(.ALU_NO(g)) u_alu (
            .clk      (clk),
            .rstn     (rstn),
            .issue    (issue_if[g]),
            .result   (result_if[g]),
            .fu_ready (fu_ready[g])
        );
    end

    writeback_arb #(.NUM_ALU(NUM_ALU)) u_arb (
        .clk      (clk),
        .rstn     (rstn),
        .result   (result_if),
        .wb_valid (wb_valid),
        .wb_data  (wb_data),
        .wb_dr    (wb_dr)
    );

endmodule

`default_nettype wire

//--- sim/exec_cluster_props.sv
`timescale 1ns/1ps
`default_nettype none

module exec_cluster_props #(
    parameter int NUM_ALU = fu_pkg::NUM_ALU_DEF
) (
    input wire               clk,
    input wire               rstn,
    input wire               issue_valid,
    input wire               issue_stall,
    input wire [NUM_ALU-1:0] sel,
    input wire               wb_valid,
    input wire               illegal_op
);

    // Failures seen, read by the testbench at the end
    int unsigned fail_count = 0;

    // Set once anything has been accepted
    logic seen_q;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            seen_q <= 1'b0;
        end else if (issue_valid && !issue_stall) begin
            seen_q <= 1'b1;
        end
    end

    ////////////////////////////////////////
    // Select and stall
    ////////////////////////////////////////

    a_sel_onehot: assert property (@(posedge clk) disable iff (!rstn) $onehot0(sel))
    else begin
        $error("more than one ALU selected in one cycle");
        fail_count++;
    end

    a_no_sel_stall: assert property (@(posedge clk) disable iff (!rstn) issue_stall |-> sel == '0)
    else begin
        $error("ALU selected while issue is stalled");
        fail_count++;
    end

    ////////////////////////////////////////
    // Outputs
    ////////////////////////////////////////

    a_wb_after_accept: assert property (@(posedge clk) disable iff (!rstn) wb_valid |-> seen_q)
    else begin
        $error("writeback with nothing accepted before");
        fail_count++;
    end

    // No unit selected on the edge that accepts an illegal op
    a_illegal_no_sel: assert property (@(posedge clk) disable iff (!rstn)
        illegal_op |-> $past(sel) == '0)
    else begin
        $error("illegal pulse after an edge that selected an ALU");
        fail_count++;
    end

endmodule

bind exec_cluster exec_cluster_props #(.NUM_ALU(NUM_ALU)) props_i (
    .clk         (clk),
    .rstn        (rstn),
    .issue_valid (issue_valid),
    .issue_stall (issue_stall),
    .sel         (u_disp.sel_vec),
    .wb_valid    (wb_valid),
    .illegal_op  (illegal_op)
);

`default_nettype wire

//--- sim/exec_cluster_tb.sv
`timescale 1ns/1ps
`default_nettype none

module exec_cluster_tb;

    // Instructions per test: 5 + 8 + 20 + 5 + 200
    localparam int N_ISSUE = 238;
    localparam int LIMIT   = 200 * N_ISSUE + 500;

    logic                 clk = 1'b0;
    logic                 rstn;
    logic                 issue_valid;
    fu_pkg::opcode_t      opcode;
    fu_pkg::funct3_t      func3;
    fu_pkg::funct7_t      func7;
    fu_pkg::word_t        data_in_sr1;
    fu_pkg::word_t        data_in_sr2;
    fu_pkg::word_t        data_in_imm;
    fu_pkg::preg_t        dr_in;
    logic                 issue_stall;
    logic                 wb_valid;
    fu_pkg::word_t        wb_data;
    fu_pkg::preg_t        wb_dr;
    logic                 illegal_op;

    // Scoreboard, indexed by tag
    bit            in_flight [64];
    fu_pkg::word_t exp_data  [64];
    int            acc_cycle [64];
    bit            timed_tag [64];
    // Cycles in which an illegal pulse is due
    bit            ill_due   [int];

    int          cycle = 0;
    int          outstanding = 0;
    int          errors = 0;
    int          checks = 0;
    int          stall_cycles = 0;
    int          ill_seen = 0;
    int          err_mark;
    int          mark;

    exec_cluster #(.NUM_ALU(3)) exec_cluster_i (.*);

    always #20 clk = ~clk;

    // Cycle count and run limit
    always @(posedge clk) begin
        cycle = cycle + 1;
        if (cycle >= LIMIT) begin
            $display("Timeout: run exceeded %0d cycles", LIMIT);
            $display("TESTS FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Output monitor, mid-cycle
    ////////////////////////////////////////

    always @(negedge clk) begin
        if (rstn) begin
            assert (illegal_op === (ill_due.exists(cycle) != 0)) else begin
                $display("Error illegal_op = %h, expected %h",
                         illegal_op, ill_due.exists(cycle) != 0);
                errors++;
            end
            if (illegal_op) ill_seen++;
            if (wb_valid) begin
                checks++;
                assert (!$isunknown(wb_dr) && in_flight[wb_dr]) else begin
                    $display("Writeback with tag %0d that is not in flight", wb_dr);
                    errors++;
                end
                if (!$isunknown(wb_dr) && in_flight[wb_dr]) begin
                    assert (wb_data === exp_data[wb_dr]) else begin
                        $display("Error wb_data = %h, expected %h (wb_dr = %h)",
                                 wb_data, exp_data[wb_dr], wb_dr);
                        errors++;
                    end
                    // One-cycle op issued alone, two cycles to writeback
                    if (timed_tag[wb_dr]) begin
                        assert (cycle == acc_cycle[wb_dr] + 2) else begin
                            $display("Writeback of tag %0d came %0d cycles after accept, not 2",
                                     wb_dr, cycle - acc_cycle[wb_dr]);
                            errors++;
                        end
                    end
                    in_flight[wb_dr] = 1'b0;
                    outstanding--;
                end
            end
        end
    end

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    // Random tag not in flight
    function automatic fu_pkg::preg_t free_tag();
        fu_pkg::preg_t t;
        t = fu_pkg::preg_t'($urandom);
        while (in_flight[t]) t = t + 1'b1;
        return t;
    endfunction

    // Drive one instruction and hold it until accepted
    task automatic send(input fu_pkg::opcode_t opc, input fu_pkg::funct3_t f3,
                        input fu_pkg::funct7_t f7, input fu_pkg::word_t a,
                        input fu_pkg::word_t b, input fu_pkg::word_t imm,
                        input bit legal, input fu_pkg::word_t exp, input bit timed);
        fu_pkg::preg_t tag;
        begin
            tag = fu_pkg::preg_t'($urandom);
            if (legal) begin
                tag = free_tag();
                in_flight[tag] = 1'b1;
                exp_data[tag]  = exp;
                timed_tag[tag] = timed;
                outstanding++;
            end
            issue_valid <= 1'b1;
            opcode      <= opc;
            func3       <= f3;
            func7       <= f7;
            data_in_sr1 <= a;
            data_in_sr2 <= b;
            data_in_imm <= imm;
            dr_in       <= tag;
            @(negedge clk);
            while (issue_stall) begin
                stall_cycles++;
                @(negedge clk);
            end
            // Next edge accepts
            if (legal) acc_cycle[tag] = cycle + 1;
            else ill_due[cycle + 1] = 1'b1;
            @(posedge clk);
        end
    endtask

    // Kinds 0..5 legal ops, 6..9 illegal encodings
    task automatic send_op(input int kind, input bit timed);
        fu_pkg::word_t a;
        fu_pkg::word_t b;
        fu_pkg::word_t imm;
        fu_pkg::shamt_t sh;
        begin
            a   = $urandom;
            b   = $urandom;
            imm = $urandom;
            sh  = imm[4:0];
            case (kind)
                0: send(7'b0110011, 3'b000, 7'b0000000, a, b, imm, 1'b1, a + b, timed);
                1: send(7'b0110011, 3'b100, 7'b0000000, a, b, imm, 1'b1, a ^ b, timed);
                2: send(7'b0010011, 3'b000, 7'b0000000, a, b, imm, 1'b1, a + imm, timed);
                3: send(7'b0010011, 3'b110, 7'b0000000, a, b, imm, 1'b1, a | imm, timed);
                // Arithmetic shift, sign fill
                4: send(7'b0010011, 3'b101, 7'b0100000, a, b, imm, 1'b1,
                        fu_pkg::word_t'($signed(a) >>> sh), timed);
                5: send(7'b0110111, 3'b000, 7'b0000000, a, b, imm, 1'b1, imm << 12, timed);
                // Load, store
                6: send(7'b0000011, 3'b010, 7'b0000000, a, b, imm, 1'b0, '0, 1'b0);
                7: send(7'b0100011, 3'b010, 7'b0000000, a, b, imm, 1'b0, '0, 1'b0);
                // ADD with non-zero func7
                8: send(7'b0110011, 3'b000, 7'b0000001, a, b, imm, 1'b0, '0, 1'b0);
                default: send(7'b1111111, 3'b000, 7'b0000000, a, b, imm, 1'b0, '0, 1'b0);
            endcase
        end
    endtask

    // Idle until every tag is back, then a short settle
    task automatic drain();
        begin
            issue_valid <= 1'b0;
            @(negedge clk);
            while (outstanding != 0) @(negedge clk);
            repeat (3) @(negedge clk);
            @(posedge clk);
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        $display("%s: %0d errors", name, errors - err_before);
    endtask

    initial begin
        void'($urandom(32'h467c));
        rstn        = 1'b0;
        issue_valid = 1'b0;
        opcode      = '0;
        func3       = '0;
        func7       = '0;
        data_in_sr1 = '0;
        data_in_sr2 = '0;
        data_in_imm = '0;
        dr_in       = '0;
        repeat (16) @(posedge clk);
        rstn <= 1'b1;
        @(posedge clk);

        // One-cycle ops, one at a time
        err_mark = errors;
        for (int k = 0; k < 6; k++) begin
            if (k != 4) begin
                send_op(k, 1'b1);
                drain();
            end
        end
        report_test("test 1 one-cycle ops", err_mark);

        err_mark = errors;
        repeat (8) begin
            send_op(4, 1'b0);
            drain();
        end
        report_test("test 2 srai", err_mark);

        // Back to back until the units fill
        err_mark = errors;
        mark = stall_cycles;
        repeat (20) send_op($urandom % 6, 1'b0);
        drain();
        assert (stall_cycles > mark) else begin
            $display("issue_stall never rose during back-to-back issue");
            errors++;
        end
        report_test("test 3 back-to-back", err_mark);

        err_mark = errors;
        mark = ill_seen;
        for (int k = 6; k < 10; k++) begin
            send_op(k, 1'b0);
            drain();
        end
        assert (ill_seen == mark + 4) else begin
            $display("Error ill_seen = %h, expected %h", ill_seen - mark, 4);
            errors++;
        end
        send_op(0, 1'b0);
        drain();
        report_test("test 4 illegal encodings", err_mark);

        // Long mix with gaps
        err_mark = errors;
        repeat (200) begin
            if ($urandom % 5 == 0) send_op(6 + $urandom % 4, 1'b0);
            else send_op($urandom % 6, 1'b0);
            if ($urandom % 4 == 0) begin
                issue_valid <= 1'b0;
                @(posedge clk);
            end
        end
        drain();
        assert (outstanding == 0 && !issue_stall) else begin
            $display("Run ended with %0d tags outstanding or stall high", outstanding);
            errors++;
        end
        for (int t = 0; t < 64; t++) begin
            assert (!in_flight[t]) else begin
                $display("Scoreboard still holds tag %0d", t);
                errors++;
            end
        end
        report_test("test 5 random mix", err_mark);

        errors += exec_cluster_i.props_i.fail_count;
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- exec_cluster.f
logic/fu_pkg.sv
logic/alu_issue_if.sv
logic/op_decoder.sv
logic/shift_timer.sv
logic/dispatch_fsm.sv
logic/alu.sv
logic/writeback_arb.sv
logic/exec_cluster.sv
sim/exec_cluster_props.sv
sim/exec_cluster_tb.sv

//--- Bender.yml
package:
  name: exec_cluster

sources:
  # RTL in compile order
  - logic/fu_pkg.sv
  - logic/alu_issue_if.sv
  - logic/op_decoder.sv
  - logic/shift_timer.sv
  - logic/dispatch_fsm.sv
  - logic/alu.sv
  - logic/writeback_arb.sv
  - logic/exec_cluster.sv
  # Testbench and bound assertions
  - target: simulation
    files:
      - sim/exec_cluster_props.sv
      - sim/exec_cluster_tb.sv
